//--- include/checker_params.svh
`ifndef CHECKER_PARAMS_SVH
`define CHECKER_PARAMS_SVH

// ==================================================
// socket and selection
// ==================================================
`define PIN_COUNT 14     // 14-pin DIP, bit i-1 is pin i
`define SEL_WIDTH 4      // switch code width

// ==================================================
// sweep timing
// ==================================================
`define SETTLE_CYCLES 3  // hold time before sampling
`define VEC_COUNT 4      // two-input combinations 00..11

// ==================================================
// seven-segment codes, active low, gfedcba
// ==================================================
`define SEG_P     7'b0001100  // letter P
`define SEG_F     7'b0001110  // letter F
`define SEG_DASH  7'b0111111  // middle bar only
`define SEG_BLANK 7'b1111111  // all off

`endif

//--- src/checkerPkg.sv
package checkerPkg;

	// ==================================================
	// chip types under test
	// ==================================================
	typedef enum logic [2:0]
	{
		chipNone,   // unknown or unsupported code
		chip7400,   // quad 2-in NAND
		chip7402,   // quad 2-in NOR
		chip7404,   // hex inverter
		chip7486    // quad 2-in XOR
	} chipType;

	// top-level sequencing
	typedef enum logic [1:0]
	{
		stIdle,
		stCheck,
		stShow
	} ctrlState;

	// per-vector drive / settle / sample
	typedef enum logic [1:0]
	{
		swIdle,
		swDrive,
		swSample
	} sweepState;

endpackage

//--- src/chipDecoder.sv
`timescale 1ns/1ns
`include "checker_params.svh"

module chipDecoder
(
	input  logic [`SEL_WIDTH-1:0] sel,
	output checkerPkg::chipType   chip,
	output logic [`PIN_COUNT-1:0] pinOe
);

	// ==================================================
	// selection code to chip and drive mask
	// ==================================================
	// codes follow the old board numbering, so 4..8 are gaps
	// mask bit i-1 drives pin i, power pins 7/14 always 0
	always_comb
	begin
		chip  = checkerPkg::chipNone;
		pinOe = '0;
		unique case (sel)
			`SEL_WIDTH'(1):
			begin
				chip  = checkerPkg::chip7400;
				pinOe = 14'b01_1011_0001_1011;  // pins 1,2,4,5,9,10,12,13
			end
			`SEL_WIDTH'(2):
			begin
				chip  = checkerPkg::chip7402;
				pinOe = 14'b00_1101_1011_0110;  // pins 2,3,5,6,8,9,11,12
			end
			`SEL_WIDTH'(3):
			begin
				chip  = checkerPkg::chip7404;
				pinOe = 14'b01_0101_0001_0101;  // pins 1,3,5,9,11,13
			end
			`SEL_WIDTH'(9):
			begin
				// same pinout as the NAND part
				chip  = checkerPkg::chip7486;
				pinOe = 14'b01_1011_0001_1011;
			end
			default:
			begin
				chip  = checkerPkg::chipNone;  // nothing driven
				pinOe = '0;
			end
		endcase
	end

	// ==================================================
	// notes on the pinouts
	// ==================================================
	// 7400/7486: A on 1,4,9,12  B on 2,5,10,13  Y on 3,6,8,11
	// 7402:      Y on 1,4,10,13  A on 2,5,8,11  B on 3,6,9,12
	// 7404:      A on odd pins 1..13 except 7, Y on the even pins
	// undriven pins become reads in the socket

endmodule

//--- src/checkerControl.sv
`timescale 1ns/1ns

module checkerControl
(
	input  logic                Clk,
	input  logic                reset,
	input  logic                run,
	input  checkerPkg::chipType chip,
	input  logic                sweepDone,
	input  logic                sweepFail,
	output logic                sweepStart,
	output logic                busy,
	output logic                checkDone,
	output logic                verdictValid,
	output logic                verdictFail
);

	checkerPkg::ctrlState state;
	checkerPkg::chipType  checkedChip;  // chip at start of last check
	logic runSync;     // button sync stage
	logic runPrev;     // previous synced level
	logic runRise;
	logic verdictHeld; // a verdict exists for checkedChip
	logic startOk;

	assign runRise = runSync & ~runPrev;
	// only place where unsupported codes get refused
	assign startOk = runRise && (chip != checkerPkg::chipNone);

	// ==================================================
	// sequencing FSM
	// ==================================================
	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state       <= checkerPkg::stIdle;
			runSync     <= 1'b0;
			runPrev     <= 1'b0;
			sweepStart  <= 1'b0;
			checkDone   <= 1'b0;
			verdictHeld <= 1'b0;
			verdictFail <= 1'b0;
		end
		else
		begin
			runSync    <= run;
			runPrev    <= runSync;
			sweepStart <= 1'b0;  // pulses by default
			checkDone  <= 1'b0;
			unique case (state)
				checkerPkg::stIdle, checkerPkg::stShow:
				begin
					if (startOk)
					begin
						sweepStart  <= 1'b1;
						checkedChip <= chip;
						verdictHeld <= 1'b0;  // old verdict goes away
						state       <= checkerPkg::stCheck;
					end
				end
				checkerPkg::stCheck:
				begin
					// run edges ignored here
					if (sweepDone)
					begin
						verdictFail <= sweepFail;
						verdictHeld <= 1'b1;
						checkDone   <= 1'b1;
						state       <= checkerPkg::stShow;
					end
				end
				default: state <= checkerPkg::stIdle;
			endcase
		end
	end

	assign busy = (state == checkerPkg::stCheck);
	// verdict goes stale once sel leaves the tested part
	assign verdictValid = verdictHeld && (chip == checkedChip);

	// sweep may only finish a sweep that this FSM started
	assert property (@(posedge Clk) disable iff (reset)
		sweepDone |-> state == checkerPkg::stCheck);

endmodule

//--- src/vectorSweep.sv
`timescale 1ns/1ns
`include "checker_params.svh"

module vectorSweep
(
	input  logic                  Clk,
	input  logic                  reset,
	input  checkerPkg::chipType   chip,
	input  logic                  sweepStart,
	input  logic [`PIN_COUNT-1:0] pinIn,
	output logic [`PIN_COUNT-1:0] pinOut,
	output logic                  sweepDone,
	output logic                  sweepFail
);

	localparam int VEC_W = $clog2(`VEC_COUNT);
	localparam int SET_W = $clog2(`SETTLE_CYCLES);

	checkerPkg::sweepState state;
	logic [VEC_W-1:0] vecCnt;     // current input combination
	logic [SET_W-1:0] settleCnt;
	logic failSticky;
	logic inA, inB;               // gate inputs of this vector
	logic expY;                   // expected gate output
	logic [`PIN_COUNT-1:0] aMask, bMask, outMask;
	logic samplePoint;
	logic mismatch;

	assign inA = vecCnt[1];
	assign inB = vecCnt[0];      // inverter sees only this one

	// ==================================================
	// pinout and truth table per chip
	// ==================================================
	always_comb
	begin
		aMask   = '0;
		bMask   = '0;
		outMask = '0;
		expY    = 1'b0;
		unique case (chip)
			checkerPkg::chip7400:
			begin
				aMask   = 14'h0909;  // 1,4,9,12
				bMask   = 14'h1212;  // 2,5,10,13
				outMask = 14'h04A4;  // 3,6,8,11
				expY    = ~(inA & inB);
			end
			checkerPkg::chip7486:
			begin
				aMask   = 14'h0909;
				bMask   = 14'h1212;
				outMask = 14'h04A4;
				expY    = inA ^ inB;
			end
			checkerPkg::chip7402:
			begin
				aMask   = 14'h0492;  // 2,5,8,11
				bMask   = 14'h0924;  // 3,6,9,12
				outMask = 14'h1209;  // 1,4,10,13
				expY    = ~(inA | inB);
			end
			checkerPkg::chip7404:
			begin
				bMask   = 14'h1515;  // odd pins
				outMask = 14'h0AAA;  // even pins below 14
				expY    = ~inB;
			end
			default: expY = 1'b0;  // no part so nothing to drive
		endcase
	end

	// vector sits on the pins from drive through the last settle cycle
	assign pinOut = (state == checkerPkg::swIdle) ? '0 :
		(({`PIN_COUNT{inA}} & aMask) | ({`PIN_COUNT{inB}} & bMask));

	assign samplePoint = (state == checkerPkg::swSample)
		&& (settleCnt == SET_W'(`SETTLE_CYCLES - 1));
	// all gates see the same vector so one expected bit serves every pin
	assign mismatch  = |((pinIn ^ {`PIN_COUNT{expY}}) & outMask);
	assign sweepDone = samplePoint && (vecCnt == VEC_W'(`VEC_COUNT - 1));
	assign sweepFail = failSticky | (samplePoint & mismatch);  // includes last vector

	// ==================================================
	// sweep FSM
	// ==================================================
	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state      <= checkerPkg::swIdle;
			vecCnt     <= '0;
			settleCnt  <= '0;
			failSticky <= 1'b0;
		end
		else
		begin
			unique case (state)
				checkerPkg::swIdle:
				begin
					if (sweepStart)
					begin
						vecCnt     <= '0;
						failSticky <= 1'b0;  // fresh check
						state      <= checkerPkg::swDrive;
					end
				end
				checkerPkg::swDrive:
				begin
					settleCnt <= '0;
					state     <= checkerPkg::swSample;
				end
				checkerPkg::swSample:
				begin
					if (samplePoint)
					begin
						failSticky <= failSticky | mismatch;
						if (sweepDone)
							state <= checkerPkg::swIdle;
						else
						begin
							vecCnt <= vecCnt + 1'b1;
							state  <= checkerPkg::swDrive;
						end
					end
					else
						settleCnt <= settleCnt + 1'b1;
				end
				default: state <= checkerPkg::swIdle;
			endcase
		end
	end

	// controller must wait for sweepDone before restarting
	assert property (@(posedge Clk) disable iff (reset)
		sweepStart |-> state == checkerPkg::swIdle);

	// controller refuses unsupported parts before starting
	assert property (@(posedge Clk) disable iff (reset)
		sweepStart |-> chip != checkerPkg::chipNone);

endmodule

//--- src/resultDisplay.sv
`timescale 1ns/1ns
`include "checker_params.svh"

module resultDisplay
(
	input  logic                  Clk,
	input  logic                  reset,
	input  logic [`SEL_WIDTH-1:0] sel,
	input  checkerPkg::chipType   chip,
	input  logic                  verdictValid,
	input  logic                  verdictFail,
	output logic [6:0]            hexSel,
	output logic [6:0]            hexResult
);

	logic [6:0] selSeg;   // hex glyph of sel
	logic [6:0] resSeg;   // next verdict glyph

	// ==================================================
	// hex digit glyphs, active low gfedcba
	// ==================================================
	always_comb
	begin
		unique case (sel)
			4'h0: selSeg = 7'b1000000;
			4'h1: selSeg = 7'b1111001;
			4'h2: selSeg = 7'b0100100;
			4'h3: selSeg = 7'b0110000;
			4'h4: selSeg = 7'b0011001;
			4'h5: selSeg = 7'b0010010;
			4'h6: selSeg = 7'b0000010;
			4'h7: selSeg = 7'b1111000;
			4'h8: selSeg = 7'b0000000;
			4'h9: selSeg = 7'b0010000;
			4'hA: selSeg = 7'b0001000;
			4'hB: selSeg = 7'b0000011;  // lower-case b
			4'hC: selSeg = 7'b1000110;
			4'hD: selSeg = 7'b0100001;  // lower-case d
			4'hE: selSeg = 7'b0000110;
			default: selSeg = 7'b0001110;  // F
		endcase
	end

	// dash wins over any verdict for an unknown code
	assign resSeg = (chip == checkerPkg::chipNone) ? `SEG_DASH :
		!verdictValid ? `SEG_BLANK :
		verdictFail   ? `SEG_F : `SEG_P;

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			hexSel    <= `SEG_BLANK;
			hexResult <= `SEG_BLANK;
		end
		else
		begin
			hexSel    <= selSeg;
			hexResult <= resSeg;  // one cycle behind checkDone
		end
	end

endmodule

//--- src/chipChecker.sv
`timescale 1ns/1ns
`include "checker_params.svh"

module chipChecker
(
	input  logic                  Clk,
	input  logic                  reset,
	input  logic [`SEL_WIDTH-1:0] sel,        // switches
	input  logic                  run,        // button level
	input  logic [`PIN_COUNT-1:0] pinIn,      // socket read back
	output logic [`PIN_COUNT-1:0] pinOut,     // socket drive value
	output logic [`PIN_COUNT-1:0] pinOe,      // socket drive enable
	output logic [6:0]            hexSel,
	output logic [6:0]            hexResult,
	output logic                  busy,
	output logic                  checkDone
);

	checkerPkg::chipType chip;
	logic sweepStart;
	logic sweepDone;
	logic sweepFail;
	logic verdictValid;
	logic verdictFail;

	// ==================================================
	// decode, sequence, sweep, show
	// ==================================================
	chipDecoder decode0
	(
		.sel   (sel),
		.chip  (chip),
		.pinOe (pinOe)
	);

	checkerControl control0
	(
		.Clk          (Clk),
		.reset        (reset),
		.run          (run),
		.chip         (chip),
		.sweepDone    (sweepDone),
		.sweepFail    (sweepFail),
		.sweepStart   (sweepStart),
		.busy         (busy),
		.checkDone    (checkDone),
		.verdictValid (verdictValid),
		.verdictFail  (verdictFail)
	);

	vectorSweep sweep0
	(
		.Clk        (Clk),
		.reset      (reset),
		.chip       (chip),
		.sweepStart (sweepStart),
		.pinIn      (pinIn),
		.pinOut     (pinOut),
		.sweepDone  (sweepDone),
		.sweepFail  (sweepFail)
	);

	resultDisplay display0
	(
		.Clk          (Clk),
		.reset        (reset),
		.sel          (sel),
		.chip         (chip),
		.verdictValid (verdictValid),
		.verdictFail  (verdictFail),
		.hexSel       (hexSel),
		.hexResult    (hexResult)
	);

endmodule

//--- dv/chipModel.sv
`timescale 1ns/1ns
`include "checker_params.svh"

module chipModel
(
	input  logic [`SEL_WIDTH-1:0] code,      // part sitting in the socket
	input  logic [3:0]            faultPin,  // pin number to invert, 0 = healthy part
	input  logic [`PIN_COUNT-1:0] pinOut,
	input  logic [`PIN_COUNT-1:0] pinOe,
	output logic [`PIN_COUNT-1:0] pinIn
);

	logic [`PIN_COUNT-1:0] gateOut;   // what the gates put on their pins
	logic [`PIN_COUNT-1:0] readBack;

	// one gate of the part
	function automatic logic gate(input logic [`SEL_WIDTH-1:0] c, input logic a, input logic b);
		case (c)
			4'd1: return ~(a & b);  // 7400
			4'd2: return ~(a | b);  // 7402
			4'd9: return a ^ b;     // 7486
			default: return ~a;     // 7404, b unused
		endcase
	endfunction

	// bit n-1 is pin n
	always_comb
	begin
		gateOut = '0;
		case (code)
			4'd1, 4'd9:
			begin
				gateOut[2]  = gate(code, pinOut[0], pinOut[1]);    // pin 3
				gateOut[5]  = gate(code, pinOut[3], pinOut[4]);    // pin 6
				gateOut[7]  = gate(code, pinOut[8], pinOut[9]);    // pin 8
				gateOut[10] = gate(code, pinOut[11], pinOut[12]);  // pin 11
			end
			4'd2:
			begin
				gateOut[0]  = gate(code, pinOut[1], pinOut[2]);    // pin 1
				gateOut[3]  = gate(code, pinOut[4], pinOut[5]);    // pin 4
				gateOut[9]  = gate(code, pinOut[7], pinOut[8]);    // pin 10
				gateOut[12] = gate(code, pinOut[10], pinOut[11]);  // pin 13
			end
			4'd3:
			begin
				// inverter pairs 1>2 3>4 5>6 9>8 11>10 13>12
				gateOut[1]  = gate(code, pinOut[0], 1'b0);
				gateOut[3]  = gate(code, pinOut[2], 1'b0);
				gateOut[5]  = gate(code, pinOut[4], 1'b0);
				gateOut[7]  = gate(code, pinOut[8], 1'b0);
				gateOut[9]  = gate(code, pinOut[10], 1'b0);
				gateOut[11] = gate(code, pinOut[12], 1'b0);
			end
			default: gateOut = '0;  // empty socket
		endcase
	end

	assign readBack = (pinOut & pinOe) | (gateOut & ~pinOe);  // driven pins echo back
	assign pinIn = (faultPin == 4'd0) ? readBack :
		readBack ^ (`PIN_COUNT'(1) << (faultPin - 4'd1));

endmodule

//--- dv/chipChecker_tb.sv
`timescale 1ns/1ns
`include "checker_params.svh"

module chipChecker_tb;

	logic Clk;
	logic reset;
	logic run;
	logic [`SEL_WIDTH-1:0] sel;
	logic [3:0] faultPin;
	logic [`PIN_COUNT-1:0] pinIn, pinOut, pinOe;
	logic [6:0] hexSel, hexResult;
	logic busy, checkDone;
	logic [7:0] lfsr;
	int errors;
	int cycles;     // watchdog count
	int doneCount;  // checkDone pulses seen

	chipChecker dut0 (.Clk(Clk), .reset(reset), .sel(sel), .run(run), .pinIn(pinIn),
		.pinOut(pinOut), .pinOe(pinOe), .hexSel(hexSel), .hexResult(hexResult),
		.busy(busy), .checkDone(checkDone));

	chipModel model0 (.code(sel), .faultPin(faultPin), .pinOut(pinOut), .pinOe(pinOe),
		.pinIn(pinIn));

	always #2 Clk = ~Clk;  // 4 ns period

	// ==================================================
	// watchdog and pulse counter
	// ==================================================
	always @(posedge Clk)
	begin
		cycles++;
		if (cycles >= 2000)  // ~30 checks of 18 cycles plus waits fit well below
		begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	always @(negedge Clk)
		if (!reset && checkDone)
			doneCount++;

	// ==================================================
	// expected values and helpers
	// ==================================================
	function automatic logic [`PIN_COUNT-1:0] pinBit(input int n);
		return `PIN_COUNT'(1) << (n - 1);
	endfunction

	// drive masks from the datasheet pinouts
	function automatic logic [`PIN_COUNT-1:0] driveMask(input logic [3:0] code);
		case (code)
			4'd1, 4'd9: return pinBit(1) | pinBit(2) | pinBit(4) | pinBit(5)
				| pinBit(9) | pinBit(10) | pinBit(12) | pinBit(13);
			4'd2: return pinBit(2) | pinBit(3) | pinBit(5) | pinBit(6)
				| pinBit(8) | pinBit(9) | pinBit(11) | pinBit(12);
			4'd3: return pinBit(1) | pinBit(3) | pinBit(5) | pinBit(9) | pinBit(11) | pinBit(13);
			default: return '0;
		endcase
	endfunction

	// output pin idx of a part wrapping on the gate count
	function automatic logic [3:0] outPin(input logic [3:0] code, input int idx);
		logic [3:0] pins [6];
		case (code)
			4'd2: pins = '{4'd1, 4'd4, 4'd10, 4'd13, 4'd1, 4'd4};
			4'd3: pins = '{4'd2, 4'd4, 4'd6, 4'd8, 4'd10, 4'd12};
			default: pins = '{4'd3, 4'd6, 4'd8, 4'd11, 4'd3, 4'd6};
		endcase
		return (code == 4'd3) ? pins[idx % 6] : pins[idx % 4];
	endfunction

	function automatic logic [3:0] codeOf(input int idx);
		case (idx)
			0: return 4'd1;
			1: return 4'd2;
			2: return 4'd3;
			default: return 4'd9;
		endcase
	endfunction

	function automatic logic [6:0] digitSeg(input logic [3:0] code);
		case (code)
			4'd1: return 7'b1111001;  // b c
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd5: return 7'b0010010;
			4'd9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	// x^8+x^6+x^5+x^4+1 stepped once per bit
	function automatic logic [7:0] randBits(input int n);
		logic [7:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
			val = {val[6:0], lfsr[7]};
			lfsr = {lfsr[6:0], fb};
		end
		return val;
	endfunction

	task automatic reportMismatch(input string what, input logic [13:0] got,
		input logic [13:0] exp);
		errors++;
		$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic pulseRun();
		@(posedge Clk);
		run <= 1'b1;
		repeat (2) @(posedge Clk);
		run <= 1'b0;
	endtask

	// got stays low if 40 cycles pass without checkDone
	task automatic waitDone(output logic got);
		int n;
		got = 1'b0;
		n = 0;
		while (!got && n < 40)
		begin
			@(negedge Clk);
			if (checkDone)
				got = 1'b1;
			n++;
		end
	endtask

	// ==================================================
	// directed tests
	// ==================================================
	task automatic checkChip(input logic [3:0] code, input logic [3:0] fault, input logic expFail);
		logic got;
		logic [6:0] expSeg;
		expSeg = expFail ? `SEG_F : `SEG_P;
		@(posedge Clk);
		sel      <= code;
		faultPin <= fault;
		pulseRun();
		waitDone(got);
		if (!got)
		begin
			errors++;
			$display("%0t ns: code %0d gave no checkDone within 40 cycles", $time, code);
		end
		else
		begin
			@(negedge Clk);  // display is one cycle behind
			if (hexResult != expSeg)
				reportMismatch($sformatf("hexResult code %0d fault %0d", code, fault),
					14'(hexResult), 14'(expSeg));
			if (hexSel != digitSeg(code))
				reportMismatch("hexSel", 14'(hexSel), 14'(digitSeg(code)));
		end
	endtask

	task automatic afterReset();
		@(negedge Clk);
		if (busy != 1'b0)
			reportMismatch("busy", 14'(busy), 14'd0);
		if (pinOut != '0)
			reportMismatch("pinOut", pinOut, 14'd0);
		if (hexResult != `SEG_BLANK)
			reportMismatch("hexResult", 14'(hexResult), 14'(`SEG_BLANK));
		for (int i = 0; i < 4; i++)
		begin
			@(posedge Clk);
			sel <= codeOf(i);
			@(negedge Clk);
			if (pinOe != driveMask(codeOf(i)))
				reportMismatch($sformatf("pinOe code %0d", codeOf(i)), pinOe,
					driveMask(codeOf(i)));
		end
	endtask

	task automatic unsupportedCode();
		@(posedge Clk);
		sel      <= 4'd5;
		faultPin <= 4'd0;
		pulseRun();
		repeat (40)  // no check may start
		begin
			@(negedge Clk);
			if (busy)
				reportMismatch("busy for code 5", 14'(busy), 14'd0);
			if (checkDone)
				reportMismatch("checkDone for code 5", 14'(checkDone), 14'd0);
		end
		if (hexResult != `SEG_DASH)
			reportMismatch("hexResult code 5", 14'(hexResult), 14'(`SEG_DASH));
		if (hexSel != digitSeg(4'd5))
			reportMismatch("hexSel code 5", 14'(hexSel), 14'(digitSeg(4'd5)));
	endtask

	task automatic randomChecks();
		logic [3:0] code;
		logic inject;
		int idx;
		for (int r = 0; r < 20; r++)
		begin
			code   = codeOf(int'(randBits(2)));
			inject = |randBits(1);
			idx    = int'(randBits(3));
			checkChip(code, inject ? outPin(code, idx) : 4'd0, inject);
		end
	endtask

	task automatic recheckAndChange();
		logic got;
		int doneBefore;
		@(posedge Clk);
		sel      <= 4'd2;
		faultPin <= 4'd0;
		doneBefore = doneCount;
		pulseRun();
		repeat (3) @(negedge Clk);
		if (!busy)
		begin
			errors++;
			$display("%0t ns: checker not busy after run", $time);
		end
		pulseRun();  // second press mid-check gets ignored
		waitDone(got);
		if (!got)
		begin
			errors++;
			$display("%0t ns: recheck of code 2 gave no checkDone within 40 cycles", $time);
		end
		repeat (30) @(negedge Clk);
		if (doneCount - doneBefore != 1)
			reportMismatch("checkDone pulses", 14'(doneCount - doneBefore), 14'd1);
		if (hexResult != `SEG_P)
			reportMismatch("hexResult after recheck", 14'(hexResult), 14'(`SEG_P));
		@(posedge Clk);
		sel <= 4'd3;
		repeat (2) @(negedge Clk);
		if (hexResult != `SEG_BLANK)  // stale verdict hidden
			reportMismatch("hexResult after sel change", 14'(hexResult), 14'(`SEG_BLANK));
		checkChip(4'd3, 4'd0, 1'b0);
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial
	begin
		Clk      = 1'b0;
		reset    = 1'b1;
		run      = 1'b0;
		sel      = 4'd1;  // supported code so the result digit starts blank
		faultPin = 4'd0;
		lfsr     = 8'd48;
		errors   = 0;
		repeat (10) @(posedge Clk);
		reset <= 1'b0;
		afterReset();
		for (int i = 0; i < 4; i++)
			checkChip(codeOf(i), 4'd0, 1'b0);               // good parts
		for (int i = 0; i < 4; i++)
			checkChip(codeOf(i), outPin(codeOf(i), i), 1'b1);  // stuck output
		unsupportedCode();
		randomChecks();
		recheckAndChange();
		repeat (5) @(posedge Clk);
		$display("errors: %0d, checkDone pulses: %0d", errors, doneCount);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
src/checkerPkg.sv
src/chipDecoder.sv
src/checkerControl.sv
src/vectorSweep.sv
src/resultDisplay.sv
src/chipChecker.sv
dv/chipModel.sv
dv/chipChecker_tb.sv

//--- Makefile
TOP = chipChecker_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f filelist.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^TEST PASS$$" sim.log && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log
